// ==== ral_async_to_wormhole.sv ====
//////////////////////////////////////////////////////////////////////
// ral to wormhole clock-crossing adapter
// a ral word and its coordinate go out as three flits, three flits
// coming back are rebuilt into one ral word
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ral_async_to_wormhole
  #(parameter int lg_fifo_depth_p = 3
  )
  (input  logic                            ral_clk_i
  ,input  logic                            wh_clk_i
  ,input  logic                            rst_n_i
  ,input  wh_pkg::ral_link_s               ral_link_i
  ,output wh_pkg::ral_link_s               ral_link_o
  ,input  logic [wh_pkg::cord_width_c-1:0] ral_dest_cord_i
  ,input  wh_pkg::wh_link_s                wh_link_i
  ,output wh_pkg::wh_link_s                wh_link_o
  );

  // outgoing path
  wh_pkg::wh_packet_s              tx_packet;
  logic                            piso_ready;
  logic                            piso_v;
  logic [wh_pkg::flit_width_c-1:0] piso_flit;
  logic                            tx_full;
  logic                            tx_enq;
  logic                            tx_v;
  logic [wh_pkg::flit_width_c-1:0] tx_flit;

  // return path
  logic                            rx_full;
  logic                            rx_v;
  logic [wh_pkg::flit_width_c-1:0] rx_flit;
  logic                            sipo_ready;
  logic                            rx_deq;
  logic                            rx_packet_v;
  wh_pkg::wh_packet_s              rx_packet;

  // header built from the per-word coordinate, len is always flits minus one
  always_comb
  begin
    tx_packet.data     = ral_link_i.data;
    tx_packet.hdr.cord = ral_dest_cord_i;
    tx_packet.hdr.len  = wh_pkg::len_width_c'(wh_pkg::wh_ratio_c - 1);
  end

  wh_piso #(.payload_t(wh_pkg::wh_packet_s)) piso
    (.clk_i  (ral_clk_i)
    ,.rst_n_i(rst_n_i)
    ,.valid_i(ral_link_i.v)
    ,.ready_o(piso_ready)
    ,.data_i (tx_packet)
    ,.valid_o(piso_v)
    ,.data_o (piso_flit)
    ,.yumi_i (tx_enq)
    );

  // flit leaves the converter only when the FIFO has room
  assign tx_enq = piso_v & ~tx_full;

  wh_async_fifo
    #(.lg_fifo_depth_p(lg_fifo_depth_p)
     ,.elem_t         (logic [wh_pkg::flit_width_c-1:0])
    ) ral_to_wh
    (.w_clk_i  (ral_clk_i)
    ,.w_rst_n_i(rst_n_i)
    ,.w_enq_i  (tx_enq)
    ,.w_data_i (piso_flit)
    ,.w_full_o (tx_full)
    ,.r_clk_i  (wh_clk_i)
    ,.r_rst_n_i(rst_n_i)
    ,.r_deq_i  (tx_v & wh_link_i.ready_and_rev)
    ,.r_data_o (tx_flit)
    ,.r_valid_o(tx_v)
    );

  wh_async_fifo
    #(.lg_fifo_depth_p(lg_fifo_depth_p)
     ,.elem_t         (logic [wh_pkg::flit_width_c-1:0])
    ) wh_to_ral
    (.w_clk_i  (wh_clk_i)
    ,.w_rst_n_i(rst_n_i)
    ,.w_enq_i  (wh_link_i.v & ~rx_full)
    ,.w_data_i (wh_link_i.data)
    ,.w_full_o (rx_full)
    ,.r_clk_i  (ral_clk_i)
    ,.r_rst_n_i(rst_n_i)
    ,.r_deq_i  (rx_deq)
    ,.r_data_o (rx_flit)
    ,.r_valid_o(rx_v)
    );

  // pull flits into the converter whenever it has a free slot
  assign rx_deq = rx_v & sipo_ready;

  wh_sipo #(.payload_t(wh_pkg::wh_packet_s)) sipo
    (.clk_i  (ral_clk_i)
    ,.rst_n_i(rst_n_i)
    ,.v_i    (rx_v)
    ,.ready_o(sipo_ready)
    ,.data_i (rx_flit)
    ,.v_o    (rx_packet_v)
    ,.data_o (rx_packet)
    ,.yumi_i (rx_packet_v & ral_link_i.ready_and_rev)
    );

  // ral side outputs
  always_comb
  begin
    ral_link_o.v             = rx_packet_v;
    ral_link_o.data          = rx_packet.data;
    ral_link_o.ready_and_rev = piso_ready;
  end

  // wormhole side outputs
  always_comb
  begin
    wh_link_o.v             = tx_v;
    wh_link_o.data          = tx_flit;
    wh_link_o.ready_and_rev = ~rx_full;
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the ral to wormhole adapter testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
build_dir=obj_dir

verilator --binary --timing --assert --top-module tb_top \
  --Mdir "$build_dir" -o tb_sim -f tb.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/tb_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

# the testbench prints the fail message on any error
if grep -q "Errors found" "$log"; then
  echo "simulation reported errors"
  exit 1
fi

exit 0

// ==== tb.f ====
wh_pkg.sv
wh_piso.sv
wh_sipo.sv
wh_async_fifo.sv
ral_async_to_wormhole.sv
tb_clk_gen.sv
tb_props.sv
tb_top.sv

// ==== tb_clk_gen.sv ====
//////////////////////////////////////////////////////////////////////
// testbench clock source
// free running clock with a set period and start phase
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen
  #(parameter real period_p = 4.0
   ,parameter real phase_p  = 0.0
  )
  (output logic clk_o
  );

  initial
  begin
    clk_o = 1'b0;
    // shift by the phase, then toggle every half period
    #(phase_p);
    forever
      #(period_p / 2.0) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// ==== tb_props.sv ====
//////////////////////////////////////////////////////////////////////
// adapter link properties
// outputs hold under back-pressure, valids stay low in reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_props
  (input logic              ral_clk_i
  ,input logic              wh_clk_i
  ,input logic              rst_n_i
  ,input wh_pkg::ral_link_s ral_in_i
  ,input wh_pkg::ral_link_s ral_out_i
  ,input wh_pkg::wh_link_s  wh_in_i
  ,input wh_pkg::wh_link_s  wh_out_i
  );

  // failed properties per clock domain
  int ral_fail_cnt = 0;
  int wh_fail_cnt  = 0;

  // returned word waits unchanged while ral side stalls
  ral_hold_a: assert property (@(posedge ral_clk_i) disable iff (!rst_n_i)
    (ral_out_i.v && !ral_in_i.ready_and_rev) |=> (ral_out_i.v && $stable(ral_out_i.data)))
  else
  begin
    $error("ral output word dropped or changed while stalled");
    ral_fail_cnt++;
  end

  // offered flit waits unchanged while wormhole side stalls
  wh_hold_a: assert property (@(posedge wh_clk_i) disable iff (!rst_n_i)
    (wh_out_i.v && !wh_in_i.ready_and_rev) |=> (wh_out_i.v && $stable(wh_out_i.data)))
  else
  begin
    $error("wormhole output flit dropped or changed while stalled");
    wh_fail_cnt++;
  end

  // sipo clears on the first reset edge
  ral_rst_a: assert property (@(posedge ral_clk_i) !rst_n_i |=> !ral_out_i.v)
  else
  begin
    $error("ral output valid high in reset");
    ral_fail_cnt++;
  end

  // fifo read side needs its two sync flops first
  wh_rst_a: assert property (@(posedge wh_clk_i) (!rst_n_i ##1 !rst_n_i) |=> !wh_out_i.v)
  else
  begin
    $error("wormhole output valid high in reset");
    wh_fail_cnt++;
  end

endmodule

`default_nettype wire

// ==== tb_top.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the ral to wormhole adapter
// table driven send, return, burst and loopback checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_top;

  localparam int          timeout_c   = 200;
  localparam int          hold_c      = 40;
  localparam int          num_tests_c = 9;
  localparam logic [31:0] seed_c      = 32'h7c0c7535;

  // ready_pat of zero means random ready
  typedef struct packed {
    logic [63:0]                     name;
    logic [wh_pkg::ral_width_c-1:0]  data;
    logic [wh_pkg::cord_width_c-1:0] cord;
    logic [7:0]                      ready_pat;
    logic                            loopback;
  } test_entry_t;

  test_entry_t tests_tbl [num_tests_c] = '{
    '{"basic_00", 32'h1234_5678, 6'h05, 8'hff, 1'b0},
    '{"zeros_01", 32'h0000_0000, 6'h00, 8'hff, 1'b0},
    '{"ones_max", 32'hffff_ffff, 6'h3f, 8'ha5, 1'b0},
    '{"alt_bits", 32'ha5a5_5a5a, 6'h2a, 8'h00, 1'b0},
    '{"rand_pat", 32'hdead_beef, 6'h11, 8'h00, 1'b0},
    '{"slow_rdy", 32'h0bad_f00d, 6'h01, 8'h81, 1'b0},
    '{"loop_one", 32'hcafe_0001, 6'h07, 8'hff, 1'b1},
    '{"loop_two", 32'h8000_0001, 6'h20, 8'hff, 1'b1},
    '{"loop_thr", 32'h1357_9bdf, 6'h33, 8'hff, 1'b1}
  };

  logic ral_clk;
  logic wh_clk;
  logic rst_n;

  // tb driven link fields
  logic                            ral_v;
  logic [wh_pkg::ral_width_c-1:0]  ral_data;
  logic [wh_pkg::cord_width_c-1:0] ral_cord;
  logic                            ral_ready;
  logic                            wh_v;
  logic [wh_pkg::flit_width_c-1:0] wh_data;
  logic                            wh_ready;
  logic                            loopback;

  wh_pkg::ral_link_s ral_link_i;
  wh_pkg::ral_link_s ral_link_o;
  wh_pkg::wh_link_s  wh_link_i;
  wh_pkg::wh_link_s  wh_link_o;

  int         errors       = 0;
  int         test_errs    = 0;
  int         tests_run    = 0;
  int         tests_failed = 0;
  logic [2:0] pat_pos      = 3'd0;

  tb_clk_gen #(.period_p(4.0), .phase_p(0.0)) ral_clk_gen (.clk_o(ral_clk));
  tb_clk_gen #(.period_p(4.0), .phase_p(1.3)) wh_clk_gen (.clk_o(wh_clk));

  assign ral_link_i = {ral_v, ral_data, ral_ready};
  // loopback hands our own flits and ready straight back
  assign wh_link_i = loopback ? wh_link_o : {wh_v, wh_data, wh_ready};

  ral_async_to_wormhole #(.lg_fifo_depth_p(3)) dut0
    (.ral_clk_i      (ral_clk)
    ,.wh_clk_i       (wh_clk)
    ,.rst_n_i        (rst_n)
    ,.ral_link_i     (ral_link_i)
    ,.ral_link_o     (ral_link_o)
    ,.ral_dest_cord_i(ral_cord)
    ,.wh_link_i      (wh_link_i)
    ,.wh_link_o      (wh_link_o)
    );

  bind ral_async_to_wormhole tb_props props0
    (.ral_clk_i(ral_clk_i)
    ,.wh_clk_i (wh_clk_i)
    ,.rst_n_i  (rst_n_i)
    ,.ral_in_i (ral_link_i)
    ,.ral_out_i(ral_link_o)
    ,.wh_in_i  (wh_link_i)
    ,.wh_out_i (wh_link_o)
    );

  // zero pad, data over cord over len of two
  function automatic logic [47:0] packet_bits(input logic [31:0] data, input logic [5:0] cord);
    return {7'b0, data, cord, 3'd2};
  endfunction

  // flit 0 is the lowest slice
  function automatic logic [15:0] flit_of(input logic [47:0] pkt, input int idx);
    return 16'(pkt >> (16 * idx));
  endfunction

  task automatic check_flit(input string name, input int idx,
                            input logic [wh_pkg::flit_width_c-1:0] exp,
                            input logic [wh_pkg::flit_width_c-1:0] act);
    if (act !== exp)
    begin
      $display("FAILED %s flit %0d expected %h actual %h", name, idx, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_ral_data(input string name,
                                input logic [wh_pkg::ral_width_c-1:0] exp,
                                input logic [wh_pkg::ral_width_c-1:0] act);
    if (act !== exp)
    begin
      $display("FAILED %s ral word expected %h actual %h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic note_error(input string name, input string what);
    $display("%s: %s", name, what);
    test_errs++;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errs != 0)
      tests_failed++;
    errors += test_errs;
    $display("test %s done, %0d errors", name, test_errs);
    test_errs = 0;
  endtask

  // cycle through the pattern, or flip a coin
  task automatic pick_wh_ready(input logic [7:0] pat);
    if (pat == 8'h00)
      wh_ready = 1'($urandom);
    else
      wh_ready = pat[pat_pos];
    pat_pos = pat_pos + 3'd1;
  endtask

  // called just after a ral edge, returns just after one
  task automatic send_ral(input string name, input logic [31:0] data, input logic [5:0] cord);
    int   n;
    logic done;
    n        = 0;
    done     = 1'b0;
    ral_v    = 1'b1;
    ral_data = data;
    ral_cord = cord;
    while (!done && n < timeout_c)
    begin
      @(posedge ral_clk);
      done = ral_link_o.ready_and_rev;
      n++;
    end
    #0.5;
    ral_v = 1'b0;
    if (!done)
      note_error(name, "ral word not accepted within limit");
  endtask

  // three flits of one packet, ready from the pattern
  task automatic recv_flits(input string name, input logic [47:0] pkt, input logic [7:0] pat);
    int   n;
    logic got;
    for (int idx = 0; idx < 3; idx++)
    begin
      n   = 0;
      got = 1'b0;
      while (!got && n < timeout_c)
      begin
        pick_wh_ready(pat);
        @(posedge wh_clk);
        if (wh_link_o.v && wh_ready)
        begin
          got = 1'b1;
          check_flit(name, idx, flit_of(pkt, idx), wh_link_o.data);
        end
        #0.5;
        n++;
      end
      if (!got)
        note_error(name, "no flit within limit");
    end
    wh_ready = 1'b0;
  endtask

  task automatic send_flits(input string name, input logic [47:0] pkt);
    int   n;
    logic done;
    for (int idx = 0; idx < 3; idx++)
    begin
      n       = 0;
      done    = 1'b0;
      wh_v    = 1'b1;
      wh_data = flit_of(pkt, idx);
      while (!done && n < timeout_c)
      begin
        @(posedge wh_clk);
        done = wh_link_o.ready_and_rev;
        n++;
      end
      #0.5;
      if (!done)
        note_error(name, "flit not accepted within limit");
    end
    wh_v = 1'b0;
  endtask

  task automatic recv_ral(input string name, input logic [31:0] exp);
    int   n;
    logic got;
    n         = 0;
    got       = 1'b0;
    ral_ready = 1'b1;
    while (!got && n < timeout_c)
    begin
      @(posedge ral_clk);
      if (ral_link_o.v)
      begin
        got = 1'b1;
        check_ral_data(name, exp, ral_link_o.data);
      end
      n++;
    end
    #0.5;
    ral_ready = 1'b0;
    if (!got)
      note_error(name, "no ral word within limit");
  endtask

  initial
  begin
    string       name;
    logic [47:0] pkt;
    int          n;
    logic        bad;
    void'($urandom(seed_c));
    rst_n     = 1'b0;
    loopback  = 1'b0;
    ral_v     = 1'b0;
    ral_data  = '0;
    ral_cord  = '0;
    ral_ready = 1'b0;
    wh_v      = 1'b0;
    wh_data   = '0;
    wh_ready  = 1'b0;

    // reset, valids low, then both readies up
    name = "reset";
    repeat (5) @(posedge ral_clk);
    if (ral_link_o.v !== 1'b0 || wh_link_o.v !== 1'b0)
      note_error(name, "output valid high during reset");
    #0.5;
    rst_n = 1'b1;
    n     = 0;
    bad   = 1'b0;
    while (!(ral_link_o.ready_and_rev && wh_link_o.ready_and_rev) && n < timeout_c)
    begin
      @(posedge ral_clk);
      if (ral_link_o.v || wh_link_o.v)
        bad = 1'b1;
      n++;
    end
    if (!(ral_link_o.ready_and_rev && wh_link_o.ready_and_rev))
      note_error(name, "ready outputs not high within limit after reset");
    if (bad)
      note_error(name, "output valid high right after reset");
    finish_test(name);

    // one word out as three flits
    for (int i = 0; i < num_tests_c; i++)
    begin
      if (!tests_tbl[i].loopback)
      begin
        name = $sformatf("%s_fwd", tests_tbl[i].name);
        pkt  = packet_bits(tests_tbl[i].data, tests_tbl[i].cord);
        fork
          begin
            @(posedge ral_clk);
            #0.5;
            send_ral(name, tests_tbl[i].data, tests_tbl[i].cord);
          end
          begin
            @(posedge wh_clk);
            #0.5;
            recv_flits(name, pkt, tests_tbl[i].ready_pat);
            // nothing beyond the third flit
            bad = 1'b0;
            repeat (8)
            begin
              @(posedge wh_clk);
              if (wh_link_o.v)
                bad = 1'b1;
            end
            if (bad)
              note_error(name, "extra flit after packet");
          end
        join
        finish_test(name);
      end
    end

    // three flits back as one word, bits 40:9
    for (int i = 0; i < num_tests_c; i++)
    begin
      if (!tests_tbl[i].loopback)
      begin
        name = $sformatf("%s_ret", tests_tbl[i].name);
        pkt  = packet_bits(tests_tbl[i].data, tests_tbl[i].cord);
        fork
          begin
            @(posedge wh_clk);
            #0.5;
            send_flits(name, pkt);
          end
          begin
            @(posedge ral_clk);
            #0.5;
            recv_ral(name, pkt[40:9]);
          end
        join
        finish_test(name);
      end
    end

    // back to back words against random wormhole ready
    name = "burst_fwd";
    fork
      begin
        @(posedge ral_clk);
        #0.5;
        for (int k = 0; k < num_tests_c; k++)
          if (!tests_tbl[k].loopback)
            send_ral(name, tests_tbl[k].data, tests_tbl[k].cord);
      end
      begin
        @(posedge wh_clk);
        #0.5;
        for (int k = 0; k < num_tests_c; k++)
          if (!tests_tbl[k].loopback)
            recv_flits(name, packet_bits(tests_tbl[k].data, tests_tbl[k].cord), 8'h00);
      end
    join
    finish_test(name);

    // return burst piles up behind a held ral ready
    name = "burst_ret";
    fork
      begin
        @(posedge wh_clk);
        #0.5;
        for (int k = 0; k < num_tests_c; k++)
          if (!tests_tbl[k].loopback)
            send_flits(name, packet_bits(tests_tbl[k].data, tests_tbl[k].cord));
      end
      begin
        @(posedge ral_clk);
        #0.5;
        repeat (hold_c) @(posedge ral_clk);
        if (!ral_link_o.v)
          note_error(name, "no return word waiting during hold");
        #0.5;
        for (int k = 0; k < num_tests_c; k++)
          if (!tests_tbl[k].loopback)
            recv_ral(name, tests_tbl[k].data);
      end
    join
    finish_test(name);

    // words go around through the wormhole side and come back
    name = "loopback";
    // wormhole side input switches just after a wh edge
    @(posedge wh_clk);
    #0.5;
    loopback = 1'b1;
    @(posedge ral_clk);
    #0.5;
    fork
      begin
        for (int k = 0; k < num_tests_c; k++)
          if (tests_tbl[k].loopback)
            send_ral(name, tests_tbl[k].data, tests_tbl[k].cord);
      end
      begin
        for (int k = 0; k < num_tests_c; k++)
          if (tests_tbl[k].loopback)
            recv_ral(name, tests_tbl[k].data);
      end
    join
    finish_test(name);

    // failed link properties count as errors
    if (dut0.props0.ral_fail_cnt + dut0.props0.wh_fail_cnt != 0)
    begin
      $display("link properties failed %0d times",
               dut0.props0.ral_fail_cnt + dut0.props0.wh_fail_cnt);
      errors += dut0.props0.ral_fail_cnt + dut0.props0.wh_fail_cnt;
    end

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== wh_async_fifo.sv ====
//////////////////////////////////////////////////////////////////////
// dual-clock FIFO
// gray-coded pointers cross between the domains through two-flop
// synchronizers, each side also synchronizes its own reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module wh_async_fifo
  #(parameter int  lg_fifo_depth_p = 3
   ,parameter type elem_t = logic [wh_pkg::flit_width_c-1:0]
  )
  (input  logic  w_clk_i
  ,input  logic  w_rst_n_i
  ,input  logic  w_enq_i
  ,input  elem_t w_data_i
  ,output logic  w_full_o
  ,input  logic  r_clk_i
  ,input  logic  r_rst_n_i
  ,input  logic  r_deq_i
  ,output elem_t r_data_o
  ,output logic  r_valid_o
  );

  localparam int depth_lp = 1 << lg_fifo_depth_p;
  // full when the top two gray bits differ and the rest match
  localparam logic [lg_fifo_depth_p:0] full_mask_lp =
    (lg_fifo_depth_p + 1)'(3) << (lg_fifo_depth_p - 1);

  elem_t mem_r [depth_lp];

  // write domain
  logic [1:0]               w_rst_sync_r;
  logic                     w_rst_n;
  logic [lg_fifo_depth_p:0] w_bin_r;
  logic [lg_fifo_depth_p:0] w_gray_r;
  logic [lg_fifo_depth_p:0] w_bin_next;
  logic [lg_fifo_depth_p:0] w_gray_next;
  logic [lg_fifo_depth_p:0] r_gray_w1_r;
  logic [lg_fifo_depth_p:0] r_gray_w2_r;
  logic                     w_push;

  // read domain
  logic [1:0]               r_rst_sync_r;
  logic                     r_rst_n;
  logic [lg_fifo_depth_p:0] r_bin_r;
  logic [lg_fifo_depth_p:0] r_gray_r;
  logic [lg_fifo_depth_p:0] r_bin_next;
  logic [lg_fifo_depth_p:0] r_gray_next;
  logic [lg_fifo_depth_p:0] w_gray_r1_r;
  logic [lg_fifo_depth_p:0] w_gray_r2_r;
  logic                     r_empty;
  logic                     r_pop;

  // write side reset sync
  always_ff @(posedge w_clk_i)
    w_rst_sync_r <= {w_rst_sync_r[0], w_rst_n_i};
  assign w_rst_n = w_rst_sync_r[1];

  // report full while still in reset so nothing is lost
  assign w_full_o    = (w_gray_r == (r_gray_w2_r ^ full_mask_lp)) | ~w_rst_n;
  assign w_push      = w_enq_i & ~w_full_o;
  assign w_bin_next  = w_bin_r + 1'b1;
  assign w_gray_next = w_bin_next ^ (w_bin_next >> 1);

  always_ff @(posedge w_clk_i)
  begin
    if (!w_rst_n)
    begin
      w_bin_r     <= '0;
      w_gray_r    <= '0;
      r_gray_w1_r <= '0;
      r_gray_w2_r <= '0;
    end
    else
    begin
      // read pointer into write clock
      r_gray_w1_r <= r_gray_r;
      r_gray_w2_r <= r_gray_w1_r;
      if (w_push)
      begin
        w_bin_r  <= w_bin_next;
        w_gray_r <= w_gray_next;
      end
    end
  end

  always_ff @(posedge w_clk_i)
  begin
    if (w_push)
      mem_r[w_bin_r[lg_fifo_depth_p-1:0]] <= w_data_i;
  end

  // read side reset sync
  always_ff @(posedge r_clk_i)
    r_rst_sync_r <= {r_rst_sync_r[0], r_rst_n_i};
  assign r_rst_n = r_rst_sync_r[1];

  // nothing offered until the read side is out of reset
  assign r_empty     = (r_gray_r == w_gray_r2_r);
  assign r_valid_o   = ~r_empty & r_rst_n;
  assign r_pop       = r_deq_i & r_valid_o;
  assign r_data_o    = mem_r[r_bin_r[lg_fifo_depth_p-1:0]];
  assign r_bin_next  = r_bin_r + 1'b1;
  assign r_gray_next = r_bin_next ^ (r_bin_next >> 1);

  always_ff @(posedge r_clk_i)
  begin
    if (!r_rst_n)
    begin
      r_bin_r     <= '0;
      r_gray_r    <= '0;
      w_gray_r1_r <= '0;
      w_gray_r2_r <= '0;
    end
    else
    begin
      // write pointer into read clock
      w_gray_r1_r <= w_gray_r;
      w_gray_r2_r <= w_gray_r1_r;
      if (r_pop)
      begin
        r_bin_r  <= r_bin_next;
        r_gray_r <= r_gray_next;
      end
    end
  end

endmodule

`default_nettype wire

// ==== wh_piso.sv ====
//////////////////////////////////////////////////////////////////////
// parallel-in serial-out converter
// takes one payload when idle and sends it out as flits, lowest first
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module wh_piso
  #(parameter type payload_t = wh_pkg::wh_packet_s
  )
  (input  logic                            clk_i
  ,input  logic                            rst_n_i
  ,input  logic                            valid_i
  ,output logic                            ready_o
  ,input  payload_t                        data_i
  ,output logic                            valid_o
  ,output logic [wh_pkg::flit_width_c-1:0] data_o
  ,input  logic                            yumi_i
  );

  // payload padded up to whole flits
  localparam int payload_width_lp = $bits(payload_t);
  localparam int els_lp = (payload_width_lp + wh_pkg::flit_width_c - 1) / wh_pkg::flit_width_c;
  localparam int padded_width_lp = els_lp * wh_pkg::flit_width_c;
  localparam int cnt_width_lp = (els_lp > 1) ? $clog2(els_lp) : 1;

  logic                       busy_r;
  logic [cnt_width_lp-1:0]    cnt_r;
  logic [padded_width_lp-1:0] shift_r;
  logic                       accept;
  logic                       last_flit;

  // one packet in flight at a time
  assign ready_o   = ~busy_r;
  assign accept    = valid_i & ~busy_r;
  assign last_flit = (cnt_r == cnt_width_lp'(els_lp - 1));

  // current flit always sits at the bottom of the shifter
  assign valid_o = busy_r;
  assign data_o  = shift_r[wh_pkg::flit_width_c-1:0];

  // flit counter and busy flag
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      busy_r <= 1'b0;
      cnt_r  <= '0;
    end
    else if (accept)
    begin
      busy_r <= 1'b1;
      cnt_r  <= '0;
    end
    else if (yumi_i & busy_r)
    begin
      // ready again the cycle after the last flit leaves
      if (last_flit)
      begin
        busy_r <= 1'b0;
        cnt_r  <= '0;
      end
      else
        cnt_r <= cnt_r + 1'b1;
    end
  end

  // payload shifter, zero padded on load
  always_ff @(posedge clk_i)
  begin
    if (accept)
      shift_r <= padded_width_lp'(data_i);
    else if (yumi_i & busy_r)
      shift_r <= shift_r >> wh_pkg::flit_width_c;
  end

endmodule

`default_nettype wire

// ==== wh_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// wormhole adapter package
// shared widths, header and packet layout, and the link structs used
// by the ral and wormhole sides of the adapter
//////////////////////////////////////////////////////////////////////

`default_nettype none

package wh_pkg;

  // ral endpoint data word
  localparam int ral_width_c = 32;
  // wormhole flit
  localparam int flit_width_c = 16;
  // flat destination coordinate
  localparam int cord_width_c = 6;
  // header length field, flits minus one
  localparam int len_width_c = 3;

  // header sits in the low bits of the packet
  typedef struct packed {
    logic [cord_width_c-1:0] cord;
    logic [len_width_c-1:0]  len;
  } wh_hdr_s;

  // ral data over header, 41 bits total
  typedef struct packed {
    logic [ral_width_c-1:0] data;
    wh_hdr_s                hdr;
  } wh_packet_s;

  // flits per packet, rounded up
  localparam int wh_ratio_c = ($bits(wh_packet_s) + flit_width_c - 1) / flit_width_c;

  // ral side link
  typedef struct packed {
    logic                   v;
    logic [ral_width_c-1:0] data;
    logic                   ready_and_rev;
  } ral_link_s;

  // wormhole side link
  typedef struct packed {
    logic                    v;
    logic [flit_width_c-1:0] data;
    logic                    ready_and_rev;
  } wh_link_s;

endpackage

`default_nettype wire

// ==== wh_sipo.sv ====
//////////////////////////////////////////////////////////////////////
// serial-in parallel-out converter
// gathers flits in arrival order into one payload and holds it until
// the consumer takes it
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module wh_sipo
  #(parameter type payload_t = wh_pkg::wh_packet_s
  )
  (input  logic                            clk_i
  ,input  logic                            rst_n_i
  ,input  logic                            v_i
  ,output logic                            ready_o
  ,input  logic [wh_pkg::flit_width_c-1:0] data_i
  ,output logic                            v_o
  ,output payload_t                        data_o
  ,input  logic                            yumi_i
  );

  // number of flit slots for one payload
  localparam int payload_width_lp = $bits(payload_t);
  localparam int els_lp = (payload_width_lp + wh_pkg::flit_width_c - 1) / wh_pkg::flit_width_c;
  localparam int padded_width_lp = els_lp * wh_pkg::flit_width_c;
  localparam int cnt_width_lp = (els_lp > 1) ? $clog2(els_lp) : 1;

  logic                       full_r;
  logic [cnt_width_lp-1:0]    cnt_r;
  logic [padded_width_lp-1:0] slots_r;
  logic                       take;
  logic                       last_slot;

  // no flits taken while a finished payload waits
  assign ready_o   = ~full_r;
  assign take      = v_i & ~full_r;
  assign last_slot = (cnt_r == cnt_width_lp'(els_lp - 1));

  assign v_o = full_r;
  // drop the padding from the top flit
  assign data_o = payload_t'(slots_r[payload_width_lp-1:0]);

  // slot counter and full flag
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      full_r <= 1'b0;
      cnt_r  <= '0;
    end
    else
    begin
      if (take)
      begin
        if (last_slot)
        begin
          // payload complete, shown next cycle
          full_r <= 1'b1;
          cnt_r  <= '0;
        end
        else
          cnt_r <= cnt_r + 1'b1;
      end
      else if (yumi_i & full_r)
        full_r <= 1'b0;
    end
  end

  // flit 0 lands in the lowest slot
  always_ff @(posedge clk_i)
  begin
    if (take)
      slots_r[cnt_r*wh_pkg::flit_width_c +: wh_pkg::flit_width_c] <= data_i;
  end

endmodule

`default_nettype wire
